// File: list.f
verilog/lpi_pkg.sv
verilog/lpi_small_fifo.sv
verilog/lpi_granter.sv
verilog/lpi_serializer.sv
verilog/lpi_reg_target.sv
verilog/lpi_link_top.sv
sim/lpi_tb.sv

// File: sim/lpi_testdata.txt
// Columns: port _ opcode _ address _ data _ expected response, all hex
// Opcodes: 0 read, 1 write, 2 add, 3 reserved
0_0_0_0000_0000
1_0_5_0000_0000
2_0_F_0000_0000
0_0_9_0000_0000
0_1_3_1234_1234
0_0_3_0000_1234
0_2_3_0001_1235
0_0_3_0000_1235
1_1_7_FFF0_FFF0
1_2_7_0020_0010
1_0_7_0000_0010
1_3_7_5555_DEAD
1_0_7_0000_0010
2_1_A_BEEF_BEEF
0_0_A_0000_BEEF
2_2_A_0011_BF00
2_0_A_0000_BF00
2_3_C_1111_DEAD
2_0_C_0000_0000
0_1_0_00FF_00FF
1_2_0_FF01_0000
2_0_0_0000_0000

// File: sim/lpi_tb.sv
/*
 * LPI link testbench
 * Directed vectors from the data file, then routing, fairness,
 * back-pressure and a seeded random phase against a reference model
 */

`timescale 1ns/1ns

module lpi_tb
  import lpi_pkg::*;
;

  localparam int NUM_PORT = 3;
  localparam int TIMEOUT = 200;
  localparam int MAX_VEC = 64;
  localparam int EXP_DEPTH = 64;
  localparam int LOG_DEPTH = 64;
  localparam int NUM_RAND = 200;

  logic clk;
  logic rst_n;
  logic [NUM_PORT-1:0] rlq_valid;
  logic [NUM_PORT*BW_QDATA-1:0] rlq_data;
  logic [NUM_PORT-1:0] rlq_ready;
  logic [NUM_PORT-1:0] rly_valid;
  logic [BW_YDATA-1:0] rly_data;
  logic [NUM_PORT-1:0] rly_ready;
  logic busy;

  logic [43:0] vectors [MAX_VEC];
  logic [15:0] ref_regs [16];
  logic [15:0] expect_mem [NUM_PORT][EXP_DEPTH];
  int sent_cnt [NUM_PORT];
  int recv_cnt [NUM_PORT];
  int accept_log [LOG_DEPTH];
  int accept_cnt;
  int checks;
  int errors;
  int timeouts;
  integer seed;
  logic [1:0] rnd_op [NUM_RAND];
  logic [1:0] rnd_off [NUM_RAND];
  logic [15:0] rnd_data [NUM_RAND];

  lpi_link_top #(
    .NUM_PORT (NUM_PORT)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .rlq_valid (rlq_valid),
    .rlq_data  (rlq_data),
    .rlq_ready (rlq_ready),
    .rly_valid (rly_valid),
    .rly_data  (rly_data),
    .rly_ready (rly_ready),
    .busy      (busy)
  );

  always
  begin
    #5 clk = ~clk;
  end

  // ********************
  // Reference model and checks
  // ********************

  function automatic logic [15:0] apply_model(input logic [1:0] op, input logic [3:0] addr,
                                              input logic [15:0] data);
    logic [15:0] result;
    case (op)
      op_read:
        result = ref_regs[addr];
      op_write:
      begin
        ref_regs[addr] = data;
        result = data;
      end
      op_add:
      begin
        result = ref_regs[addr] + data;
        ref_regs[addr] = result;
      end
      default:
        result = 16'hDEAD;
    endcase
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // ********************
  // Port drivers
  // ********************

  // Model runs at the acceptance edge so it follows the target's order
  task automatic send_request(input int port, input logic [1:0] op, input logic [3:0] addr,
                              input logic [15:0] data);
    int waited;
    logic accepted;
    waited = 0;
    accepted = 1'b0;
    @(negedge clk);
    rlq_data[port*BW_QDATA +: BW_QDATA] = {op, addr, data};
    rlq_valid[port] = 1'b1;
    while (!accepted && waited < TIMEOUT)
    begin
      @(posedge clk);
      waited++;
      accepted = rlq_ready[port];
    end
    if (accepted)
    begin
      expect_mem[port][sent_cnt[port] % EXP_DEPTH] = apply_model(op, addr, data);
      sent_cnt[port]++;
      if (accept_cnt < LOG_DEPTH)
        accept_log[accept_cnt] = port;
      accept_cnt++;
    end
    else
    begin
      $display("Timeout: port %0d request was not accepted in %0d cycles", port, TIMEOUT);
      timeouts++;
    end
    @(negedge clk);
    rlq_valid[port] = 1'b0;
  endtask

  task automatic receive_response(input int port, output logic [15:0] got);
    int waited;
    logic seen;
    logic [15:0] expected;
    waited = 0;
    seen = 1'b0;
    got = 'x;
    @(negedge clk);
    rly_ready[port] = 1'b1;
    while (!seen && waited < TIMEOUT)
    begin
      @(posedge clk);
      waited++;
      if (rly_valid[port])
      begin
        seen = 1'b1;
        got = rly_data;
        // Only the issuing port may see the response
        check_value($sformatf("route port %0d", port), 1 << port, rly_valid);
      end
    end
    @(negedge clk);
    rly_ready[port] = 1'b0;
    if (!seen)
    begin
      $display("Timeout: no response on port %0d in %0d cycles", port, TIMEOUT);
      timeouts++;
    end
    else
    begin
      expected = expect_mem[port][recv_cnt[port] % EXP_DEPTH];
      recv_cnt[port]++;
      check_value($sformatf("port %0d response %0d", port, recv_cnt[port]), expected, got);
    end
  endtask

  // Each port stays in its own quarter of the register file
  task automatic stream_port(input int port, input int n, input logic [1:0] op);
    logic [3:0] addr;
    for (int k = 0; k < n; k++)
    begin
      addr = {port[1:0], k[1:0]};
      send_request(port, op, addr, 16'(port * 4096 + k * 257 + 17));
    end
  endtask

  task automatic drain_port(input int port, input int n);
    logic [15:0] got;
    for (int k = 0; k < n; k++)
      receive_response(port, got);
  endtask

  task automatic stream_random(input int port);
    for (int i = port; i < NUM_RAND; i += NUM_PORT)
      send_request(port, rnd_op[i], {port[1:0], rnd_off[i]}, rnd_data[i]);
  endtask

  // ********************
  // Test sequence
  // ********************

  initial
  begin
    logic [43:0] vec;
    logic [15:0] got;
    int waited;
    integer r;
    clk = 1'b0;
    rst_n = 1'b0;
    rlq_valid = '0;
    rlq_data = '0;
    rly_ready = '0;
    accept_cnt = 0;
    checks = 0;
    errors = 0;
    timeouts = 0;
    for (int i = 0; i < 16; i++)
      ref_regs[i] = '0;
    for (int p = 0; p < NUM_PORT; p++)
    begin
      sent_cnt[p] = 0;
      recv_cnt[p] = 0;
    end
    seed = 32'h57cd;
    for (int i = 0; i < NUM_RAND; i++)
    begin
      r = $random(seed);
      rnd_op[i] = r[1:0];
      rnd_off[i] = r[3:2];
      rnd_data[i] = r[31:16];
    end
    $readmemh("sim/lpi_testdata.txt", vectors);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("busy after reset", 0, busy);
    check_value("rly_valid after reset", 0, rly_valid);

    // Directed vectors, one at a time
    for (int i = 0; i < MAX_VEC && !$isunknown(vectors[i]); i++)
    begin
      vec = vectors[i];
      send_request(vec[41:40], vec[37:36], vec[35:32], vec[31:16]);
      receive_response(vec[41:40], got);
      check_value($sformatf("vector %0d", i), vec[15:0], got);
    end

    // Routing with all ports at once
    fork
      stream_port(0, 1, op_add);
      stream_port(1, 1, op_add);
      stream_port(2, 1, op_add);
      drain_port(0, 1);
      drain_port(1, 1);
      drain_port(2, 1);
    join

    // Fairness with every port pending
    accept_cnt = 0;
    fork
      stream_port(0, 4, op_write);
      stream_port(1, 4, op_write);
      stream_port(2, 4, op_write);
      drain_port(0, 4);
      drain_port(1, 4);
      drain_port(2, 4);
    join
    check_value("fairness acceptances", 12, accept_cnt);
    for (int j = 0; j + 2 < accept_cnt && j + 2 < LOG_DEPTH; j++)
      check_value($sformatf("fairness window %0d", j), 1,
                  (accept_log[j] != accept_log[j+1]) && (accept_log[j] != accept_log[j+2]) &&
                  (accept_log[j+1] != accept_log[j+2]));

    // Back-pressure, port 0 stalls the FIFO head
    send_request(0, op_add, 4'h1, 16'h0B0B);
    fork
      begin
        waited = 0;
        while (!rly_valid[0] && waited < TIMEOUT)
        begin
          @(posedge clk);
          waited++;
        end
        if (!rly_valid[0])
        begin
          $display("Timeout: port 0 response never reached the FIFO head");
          timeouts++;
        end
        repeat (20)
        begin
          @(posedge clk);
          check_value("busy during stall", 1, busy);
          check_value("head held for port 0", 3'b001, rly_valid);
        end
        receive_response(0, got);
      end
      stream_port(1, 2, op_add);
      stream_port(2, 2, op_add);
      drain_port(1, 2);
      drain_port(2, 2);
    join

    // Random phase
    fork
      stream_random(0);
      stream_random(1);
      stream_random(2);
      drain_port(0, (NUM_RAND + NUM_PORT - 1) / NUM_PORT);
      drain_port(1, (NUM_RAND + NUM_PORT - 2) / NUM_PORT);
      drain_port(2, (NUM_RAND + NUM_PORT - 3) / NUM_PORT);
    join
    waited = 0;
    while (busy && waited < TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    if (busy)
    begin
      $display("Timeout: busy stayed high after the last response");
      timeouts++;
    end

    $display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: verilog/lpi_link_top.sv
/*
 * LPI link top level
 * Request ports share the register target through the serializer
 */

`timescale 1ns/1ns

module lpi_link_top
  import lpi_pkg::*;
#(
  parameter int NUM_PORT = 3
)
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [NUM_PORT-1:0]          rlq_valid,
  input  logic [NUM_PORT*BW_QDATA-1:0] rlq_data,
  output logic [NUM_PORT-1:0]          rlq_ready,
  output logic [NUM_PORT-1:0]          rly_valid,
  output logic [BW_YDATA-1:0]          rly_data,
  input  logic [NUM_PORT-1:0]          rly_ready,
  output logic                         busy
);

  // Shared channel between serializer and target
  logic                         slq_valid;
  logic [NUM_PORT+BW_QDATA-1:0] slq_data;
  logic                         slq_ready;
  logic                         sly_valid;
  logic [NUM_PORT+BW_YDATA-1:0] sly_data;
  logic                         sly_ready;

  lpi_serializer #(
    .NUM_PORT (NUM_PORT)
  ) u_serializer (
    .clk       (clk),
    .rst_n     (rst_n),
    .rlq_valid (rlq_valid),
    .rlq_data  (rlq_data),
    .rlq_ready (rlq_ready),
    .rly_valid (rly_valid),
    .rly_data  (rly_data),
    .rly_ready (rly_ready),
    .slq_valid (slq_valid),
    .slq_data  (slq_data),
    .slq_ready (slq_ready),
    .sly_valid (sly_valid),
    .sly_data  (sly_data),
    .sly_ready (sly_ready),
    .busy      (busy)
  );

  lpi_reg_target #(
    .NUM_PORT (NUM_PORT)
  ) u_target (
    .clk     (clk),
    .rst_n   (rst_n),
    .q_valid (slq_valid),
    .q_data  (slq_data),
    .q_ready (slq_ready),
    .y_valid (sly_valid),
    .y_data  (sly_data),
    .y_ready (sly_ready)
  );

endmodule

// File: verilog/lpi_reg_target.sv
/*
 * LPI register target
 * Executes read, write and add on a 16-entry register file
 * and returns one tagged response per request
 */

`timescale 1ns/1ns

module lpi_reg_target
  import lpi_pkg::*;
#(
  parameter int NUM_PORT = 3
)
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         q_valid,
  input  logic [NUM_PORT+BW_QDATA-1:0] q_data,
  output logic                         q_ready,
  output logic                         y_valid,
  output logic [NUM_PORT+BW_YDATA-1:0] y_data,
  input  logic                         y_ready
);

  localparam int NUM_REG = 2 ** BW_ADDR;

  target_state_e state;
  logic [BW_DATA-1:0] regs [NUM_REG];

  logic [NUM_PORT-1:0] q_tag;
  lpi_op_e q_op;
  logic [BW_ADDR-1:0] q_addr;
  logic [BW_DATA-1:0] q_wdata;
  logic q_fire;
  logic reg_wr;
  logic [BW_YDATA-1:0] result;

  // Parcel fields
  assign q_tag   = q_data[NUM_PORT+BW_QDATA-1 -: NUM_PORT];
  assign q_op    = lpi_op_e'(q_data[BW_QDATA-1 -: BW_OP]);
  assign q_addr  = q_data[BW_DATA +: BW_ADDR];
  assign q_wdata = q_data[BW_DATA-1:0];

  assign q_ready = (state == st_idle);
  assign y_valid = (state == st_respond);
  assign q_fire  = q_valid && q_ready;

  // ********************
  // Opcode decode
  // ********************

  always_comb
  begin
    reg_wr = 1'b0;
    result = regs[q_addr];
    case (q_op)
      op_read:
        result = regs[q_addr];
      op_write:
      begin
        reg_wr = 1'b1;
        result = q_wdata;
      end
      op_add:
      begin
        reg_wr = 1'b1;
        result = regs[q_addr] + q_wdata;
      end
      // Reserved code leaves the file alone
      default:
        result = 16'hDEAD;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= st_idle;
      for (int i = 0; i < NUM_REG; i++)
        regs[i] <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (q_fire)
            state <= st_respond;
        st_respond:
          if (y_ready)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
      if (q_fire && reg_wr)
        regs[q_addr] <= result;
    end
  end

  // Response keeps the request tag
  always_ff @(posedge clk)
  begin
    if (q_fire)
      y_data <= {q_tag, result};
  end

  a_y_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (y_valid && !y_ready) |=> $stable(y_data));

endmodule

// File: verilog/lpi_serializer.sv
/*
 * LPI serializer
 * Merges request ports onto one tagged channel by round robin and
 * routes tagged responses back to the port named by the tag
 */

`timescale 1ns/1ns

module lpi_serializer
  import lpi_pkg::*;
#(
  parameter int NUM_PORT = 3
)
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [NUM_PORT-1:0]          rlq_valid,
  input  logic [NUM_PORT*BW_QDATA-1:0] rlq_data,
  output logic [NUM_PORT-1:0]          rlq_ready,
  output logic [NUM_PORT-1:0]          rly_valid,
  output logic [BW_YDATA-1:0]          rly_data,
  input  logic [NUM_PORT-1:0]          rly_ready,
  output logic                         slq_valid,
  output logic [NUM_PORT+BW_QDATA-1:0] slq_data,
  input  logic                         slq_ready,
  input  logic                         sly_valid,
  input  logic [NUM_PORT+BW_YDATA-1:0] sly_data,
  output logic                         sly_ready,
  output logic                         busy
);

  logic [NUM_PORT-1:0] grant_list;
  logic [BW_QDATA-1:0] q_parcel;
  logic head_valid;
  logic [NUM_PORT+BW_YDATA-1:0] head_data;
  logic [NUM_PORT-1:0] head_tag;
  logic head_pop;

  // ********************
  // Request path
  // ********************

  lpi_granter #(
    .NUM_PORT (NUM_PORT)
  ) u_granter (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_list    (rlq_valid),
    .granted_ready (slq_ready),
    .grant_list    (grant_list),
    .granted_valid (slq_valid)
  );

  // One-hot mux of the granted parcel
  always_comb
  begin
    q_parcel = '0;
    for (int i = 0; i < NUM_PORT; i++)
      if (grant_list[i])
        q_parcel = q_parcel | rlq_data[i*BW_QDATA +: BW_QDATA];
  end

  // Grant doubles as the source tag
  assign slq_data  = {grant_list, q_parcel};
  assign rlq_ready = grant_list & {NUM_PORT{slq_ready}};

  // ********************
  // Response path
  // ********************

  lpi_small_fifo #(
    .BW_ENTRY (NUM_PORT + BW_YDATA)
  ) u_resp_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (sly_valid),
    .wr_data  (sly_data),
    .wr_ready (sly_ready),
    .rd_valid (head_valid),
    .rd_data  (head_data),
    .rd_pop   (head_pop)
  );

  assign head_tag  = head_data[NUM_PORT+BW_YDATA-1 -: NUM_PORT];
  assign rly_valid = head_valid ? head_tag : '0;
  assign rly_data  = head_data[BW_YDATA-1:0];

  // Pop once the tagged port takes it
  assign head_pop = |(rly_valid & rly_ready);
  assign busy     = head_valid;

  a_head_tagged: assert property (@(posedge clk) disable iff (!rst_n)
    head_valid |-> (head_tag != '0));

endmodule

// File: verilog/lpi_granter.sv
/*
 * Round-robin granter
 * Grants the first valid requester at or after a rotating pointer
 */

`timescale 1ns/1ns

module lpi_granter
#(
  parameter int NUM_PORT = 3
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_PORT-1:0] valid_list,
  input  logic                granted_ready,
  output logic [NUM_PORT-1:0] grant_list,
  output logic                granted_valid
);

  localparam int BW_PTR = (NUM_PORT > 1) ? $clog2(NUM_PORT) : 1;
  localparam logic [BW_PTR-1:0] LAST_PORT = BW_PTR'(NUM_PORT - 1);

  logic [BW_PTR-1:0] ptr;
  logic [BW_PTR-1:0] grant_idx;

  assign granted_valid = |valid_list;

  // Search starts at the pointer and wraps around
  always_comb
  begin
    int cand;
    grant_list = '0;
    grant_idx  = ptr;
    for (int off = 0; off < NUM_PORT; off++)
    begin
      cand = int'(ptr) + off;
      if (cand >= NUM_PORT)
        cand = cand - NUM_PORT;
      if (valid_list[cand] && (grant_list == '0))
      begin
        grant_list[cand] = 1'b1;
        grant_idx        = cand[BW_PTR-1:0];
      end
    end
  end

  // Served port drops to lowest priority
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ptr <= '0;
    else if (granted_valid && granted_ready)
      ptr <= (grant_idx == LAST_PORT) ? '0 : grant_idx + 1'b1;
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_list));

endmodule

// File: verilog/lpi_small_fifo.sv
/*
 * Small response FIFO
 * Three entries, first-word fall-through, head shown combinationally
 */

`timescale 1ns/1ns

module lpi_small_fifo
#(
  parameter int BW_ENTRY = 8
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_valid,
  input  logic [BW_ENTRY-1:0] wr_data,
  output logic                wr_ready,
  output logic                rd_valid,
  output logic [BW_ENTRY-1:0] rd_data,
  input  logic                rd_pop
);

  localparam int DEPTH = 3;

  logic [BW_ENTRY-1:0] mem [DEPTH];
  logic [1:0] wr_ptr;
  logic [1:0] rd_ptr;
  logic [1:0] count;
  logic do_write;
  logic do_read;

  // Pointers wrap after the last slot
  function automatic logic [1:0] next_ptr(input logic [1:0] ptr);
    return (ptr == 2'd2) ? 2'd0 : ptr + 2'd1;
  endfunction

  assign wr_ready = (count != 2'd3);
  assign rd_valid = (count != 2'd0);
  assign rd_data  = mem[rd_ptr];

  assign do_write = wr_valid && wr_ready;
  assign do_read  = rd_pop && rd_valid;

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_write)
      mem[wr_ptr] <= wr_data;
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= 2'd0;
      rd_ptr <= 2'd0;
      count  <= 2'd0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_read)
        rd_ptr <= next_ptr(rd_ptr);
      case ({do_write, do_read})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // The reader must only pop a visible head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_pop |-> rd_valid);

endmodule

// File: verilog/lpi_pkg.sv
/*
 * LPI link shared definitions
 * Parcel field widths, opcodes of the register target and target states
 */

package lpi_pkg;

  // ********************
  // Parcel fields
  // ********************

  localparam int BW_OP = 2;
  localparam int BW_ADDR = 4;
  localparam int BW_DATA = 16;

  // Request parcel without tag, from the top: opcode, address, data
  localparam int BW_QDATA = BW_OP + BW_ADDR + BW_DATA;

  // Response parcel without tag
  localparam int BW_YDATA = 16;

  // ********************
  // Encodings
  // ********************

  // Code 2'b11 is reserved
  typedef enum logic [BW_OP-1:0] {
    op_read  = 2'b00,
    op_write = 2'b01,
    op_add   = 2'b10
  } lpi_op_e;

  typedef enum logic {
    st_idle,
    st_respond
  } target_state_e;

endpackage
